/* all.f */
+incdir+.
mio_pkg.sv
mio_decode.sv
mio_regs.sv
mio_fifo.sv
mio_tx.sv
mio_top.sv
tb_mio.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MIO testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mio -f all.f -o vtb_mio
./obj_dir/vtb_mio | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
   exit 0
else
   exit 1
fi

/* tb_mio.sv */
// Testbench for the MIO transmit subsystem.
// Drives host packets into mio_top, checks register readback and response
// packets, and rebuilds serialized words from the pins with a deserializer
// model that tracks the lane settings this bench programmed.

`timescale 1ns/10ps
`default_nettype none

`include "mio_regmap.svh"

module tb_mio;
   import mio_pkg::*;

   // reset, 8 configs x 3 words of up to 32 beats x 3 cycles, 20 slow words, reg traffic
   localparam int max_cycles = 16 + 8 * (3 * (32 * 3 + 2) + 60) + 20 * (32 * 8 + 2) + 600;
   localparam logic [31:0] data_addr = 32'h0000_1000;   // outside register window

   logic                clk;
   logic                nreset;
   logic                access_in;
   logic [mio_pw-1:0]   packet_in;
   logic                wait_out;
   logic                access_out;
   logic [mio_pw-1:0]   packet_out;
   logic                wait_in;
   logic [mio_pins-1:0] tx_data;
   logic                tx_frame;
   logic                clkchange;
   logic [15:0]         clkphase0;
   logic [15:0]         clkphase1;
   logic [31:0]         dstaddr;

   integer      seed = 32'ha4140db1;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          chg_seen = 0;    // clkchange pulses observed
   int          chg_exp = 0;     // CLKDIV/CLKPHASE writes sent
   logic        saw_wait = 1'b0;
   logic [31:0] exp_q[$];        // words pushed, in order
   logic [31:0] rd_val;
   logic [mio_pw-1:0] held_pkt;

   // deserializer model state
   logic                model_on = 1'b1;
   logic [1:0]          cur_w = 2'd3;       // default 8 lanes
   logic                cur_lsb = 1'b0;
   logic                cur_pol = 1'b0;
   logic [7:0]          cur_div = 8'd7;
   logic                in_word = 1'b0;
   int                  frame_cyc;
   int                  nbeats;
   int                  step;
   logic [31:0]         rebuilt;
   logic [mio_pins-1:0] lane;
   logic [mio_pins-1:0] lane_mask;
   logic [mio_pins-1:0] beat_val;

   mio_top UUT (
      .clk, .nreset, .access_in, .packet_in, .wait_out, .access_out, .packet_out,
      .wait_in, .tx_data, .tx_frame, .clkchange, .clkphase0, .clkphase1, .dstaddr
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ##############################
   // helpers
   // ##############################
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   function automatic logic [mio_pw-1:0] make_pkt(input logic wr, input logic [31:0] dst,
                                                  input logic [31:0] data,
                                                  input logic [31:0] src);
      logic [mio_pw-1:0] p;
      p = '0;
      p[mio_wr_bit]              = wr;
      p[mio_dm_lsb +: 2]         = 2'b10;    // word transfer
      p[mio_dst_lsb +: mio_aw]   = dst;
      p[mio_data_lsb +: mio_aw]  = data;
      p[mio_src_lsb +: mio_aw]   = src;
      return p;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [3:0] off);
      return {mio_reg_base, 14'd0, off, 2'b00};
   endfunction

   function automatic logic [31:0] cfg_val(input logic dis, input logic [1:0] iw,
                                           input logic lsb, input logic pol);
      logic [31:0] c;
      c       = {11'd0, mio_def_cfg};
      c[0]    = dis;                      // tx disable
      c[5:4]  = iw;
      c[13]   = lsb;
      c[14]   = pol;
      return c;
   endfunction

   // held until accepted while wait_out is low
   task automatic send(input logic [mio_pw-1:0] p);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = p;
      while (wait_out)
         @(negedge clk);
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic write_reg(input logic [3:0] off, input logic [31:0] data);
      if (off == `MIO_CLKDIV || off == `MIO_CLKPHASE)
         chg_exp++;
      send(make_pkt(1'b1, reg_addr(off), data, 32'h0));
   endtask

   task automatic read_reg(input logic [3:0] off, input logic [31:0] src,
                           output logic [31:0] data);
      send(make_pkt(1'b0, reg_addr(off), 32'h0, src));
      while (!access_out)
         @(negedge clk);
      check_val("packet_out.write", 32'(packet_out[mio_wr_bit]), 32'h0);
      check_val("packet_out.dstaddr", packet_out[mio_dst_lsb +: mio_aw], src);
      data = packet_out[mio_data_lsb +: mio_aw];
   endtask

   task automatic read_check(input logic [3:0] off, input logic [31:0] exp);
      logic [31:0] v;
      read_reg(off, 32'h0000_0a00 + 32'(off), v);
      check_val("packet_out.data", v, exp);
   endtask

   task automatic push_word(input logic [31:0] w);
      exp_q.push_back(w);
      send(make_pkt(1'b1, data_addr, w, 32'h0));
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || in_word)
         @(negedge clk);
   endtask

   // model is paused while frame polarity may flip
   task automatic set_tx(input logic dis, input logic [1:0] iw, input logic lsb,
                         input logic pol, input logic [7:0] div);
      model_on = 1'b0;
      write_reg(`MIO_CLKDIV, {24'd0, div});
      write_reg(`MIO_CONFIG, cfg_val(dis, iw, lsb, pol));
      repeat (3) @(negedge clk);
      cur_w    = iw;
      cur_lsb  = lsb;
      cur_pol  = pol;
      cur_div  = div;
      model_on = 1'b1;
   endtask

   // ##############################
   // pin-side deserializer
   // ##############################
   always @(negedge clk)
   begin
      if (nreset && model_on)
      begin
         step      = 1 << cur_w;
         lane_mask = 8'((9'd1 << step) - 9'd1);
         if (tx_frame == ~cur_pol)
         begin
            if (!in_word)
            begin
               in_word   = 1'b1;
               frame_cyc = 0;
               nbeats    = 0;
               rebuilt   = '0;
            end
            lane = tx_data & lane_mask;
            if (frame_cyc % (int'(cur_div) + 1) == 0)
            begin
               if (cur_lsb)
                  rebuilt = rebuilt | (32'(lane) << (nbeats * step));
               else
                  rebuilt = (rebuilt << step) | 32'(lane);
               nbeats++;
               beat_val = tx_data;
            end
            else
               check_val("tx_data within beat", 32'(tx_data), 32'(beat_val));
            check_val("tx_data unused pins", 32'(tx_data & ~lane_mask), 32'h0);
            frame_cyc++;
         end
         else if (in_word)
         begin
            in_word = 1'b0;
            check_val("frame length", 32'(frame_cyc), 32'((32 / step) * (int'(cur_div) + 1)));
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("A word appeared on the pins with none pushed");
            end
            else
               check_val("rebuilt word", rebuilt, exp_q.pop_front());
         end
      end
   end

   // ##############################
   // monitors
   // ##############################
   always @(posedge clk)
   begin
      if (nreset && clkchange)
         chg_seen++;
      if (nreset && wait_out)
         saw_wait <= 1'b1;
   end

   a_resp_stable : assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |=> access_out && $stable(packet_out))
   else
   begin
      errors++;
      $display("** Error: packet_out = %h changed while wait_in high", packet_out);
   end

   a_hold_blocks : assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |-> wait_out)
   else
   begin
      errors++;
      $display("** Error: wait_out = %h low while response held", wait_out);
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > max_cycles)
      begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ##############################
   // stimulus
   // ##############################
   initial
   begin
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      repeat (16) @(negedge clk);
      check_val("access_out", 32'(access_out), 32'h0);
      check_val("wait_out", 32'(wait_out), 32'h0);
      check_val("tx_frame", 32'(tx_frame), 32'h0);
      nreset = 1'b1;

      // reset values, phases at 0/180/90/270 deg of one divided period
      read_check(`MIO_CONFIG, {11'd0, mio_def_cfg});
      read_check(`MIO_CLKDIV, {24'd0, mio_def_clk});
      read_check(`MIO_CLKPHASE, {8'((mio_def_clk + 1) * 3 / 4), 8'((mio_def_clk + 1) / 4),
                                 8'((mio_def_clk + 1) / 2), 8'd0});

      // write then read back
      write_reg(`MIO_CLKDIV, 32'h0000_003c);
      read_check(`MIO_CLKDIV, 32'h0000_003c);
      write_reg(`MIO_CLKPHASE, 32'h1234_5678);
      read_check(`MIO_CLKPHASE, 32'h1234_5678);
      check_val("clkphase0", {16'd0, clkphase0}, 32'h0000_5678);
      check_val("clkphase1", {16'd0, clkphase1}, 32'h0000_1234);
      write_reg(`MIO_ADDR0, 32'hcafe_0123);
      write_reg(`MIO_ADDR1, 32'h0bad_f00d);
      read_check(`MIO_ADDR0, 32'hcafe_0123);
      read_check(`MIO_ADDR1, 32'h0bad_f00d);
      check_val("dstaddr", dstaddr, 32'hcafe_0123);
      check_val("clkchange count", 32'(chg_seen), 32'(chg_exp));

      // every lane width and bit order
      for (int i = 0; i < 8; i++)
      begin
         wait_drain();
         set_tx(1'b0, 2'(i >> 1), 1'(i), 1'(i ^ (i >> 1)), 8'(i % 3));
         repeat (3) push_word($random(seed));
      end
      wait_drain();

      // back-pressure: queue with tx off, then stream against a slow drain
      set_tx(1'b1, 2'd0, 1'b0, 1'b0, 8'd7);
      write_reg(`MIO_STATUS, 32'h0);
      repeat (10) push_word($random(seed));
      write_reg(`MIO_CONFIG, cfg_val(1'b0, 2'd0, 1'b0, 1'b0));
      repeat (10) push_word($random(seed));
      wait_drain();
      repeat (2) @(negedge clk);
      check_val("saw wait_out", 32'(saw_wait), 32'h1);
      // sticky full, prog_full, empty in [13:11]; live empty in [3]
      read_check(`MIO_STATUS, 32'h0000_3808);
      write_reg(`MIO_STATUS, 32'h0);
      read_check(`MIO_STATUS, 32'h0000_0808);

      // response held by wait_in, a second read queued behind it
      @(negedge clk);
      wait_in = 1'b1;
      read_reg(`MIO_CLKDIV, 32'h0000_0bbb, rd_val);
      check_val("packet_out.data", rd_val, 32'h0000_0007);
      held_pkt  = packet_out;
      access_in = 1'b1;                               // stalls behind the held one
      packet_in = make_pkt(1'b0, reg_addr(`MIO_CONFIG), 32'h0, 32'h0000_0ccc);
      repeat (6) @(negedge clk);
      check_val("access_out", 32'(access_out), 32'h1);
      check_val("packet_out.data", packet_out[mio_data_lsb +: mio_aw],
                held_pkt[mio_data_lsb +: mio_aw]);
      wait_in = 1'b0;
      @(negedge clk);                                 // held response taken, read accepted
      access_in = 1'b0;
      while (!access_out)
         @(negedge clk);
      check_val("packet_out.dstaddr", packet_out[mio_dst_lsb +: mio_aw], 32'h0000_0ccc);
      check_val("packet_out.data", packet_out[mio_data_lsb +: mio_aw],
                cfg_val(1'b0, 2'd0, 1'b0, 1'b0));
      while (access_out)
         @(negedge clk);
      check_val("clkchange count", 32'(chg_seen), 32'(chg_exp));
      repeat (4) @(negedge clk);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* mio_top.sv */
// Top level of the MIO transmit subsystem.
// Host packets enter through the decoder; register reads answer on
// access_out/packet_out and data words leave on tx_data/tx_frame.

`timescale 1ns/10ps
`default_nettype none

module mio_top (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          access_in,
   input  wire  [mio_pkg::mio_pw-1:0]   packet_in,
   output logic                         wait_out,
   output logic                         access_out,
   output logic [mio_pkg::mio_pw-1:0]   packet_out,
   input  wire                          wait_in,
   output logic [mio_pkg::mio_pins-1:0] tx_data,
   output logic                         tx_frame,
   output logic                         clkchange,
   output logic [15:0]                  clkphase0,
   output logic [15:0]                  clkphase1,
   output logic [31:0]                  dstaddr
);

   logic        reg_access;       // decode to registers
   logic        reg_write;
   logic [3:0]  reg_addr;
   logic [31:0] reg_data;
   logic [31:0] reg_srcaddr;
   logic        resp_busy;
   logic        push;             // decode to fifo
   logic [31:0] push_data;
   logic        pop;              // fifo to serializer
   logic [31:0] rd_data;
   logic        full;
   logic        prog_full;
   logic        empty;
   logic        tx_en;            // register controls
   logic [1:0]  iowidth;
   logic        lsbfirst;
   logic        framepol;
   logic [7:0]  clkdiv;

   mio_decode u_decode (
      .clk, .nreset, .access_in, .packet_in, .fifo_full(full), .resp_busy,
      .wait_out, .reg_access, .reg_write, .reg_addr, .reg_data, .reg_srcaddr,
      .push, .push_data
   );

   mio_regs u_regs (
      .clk, .nreset, .reg_access, .reg_write, .reg_addr, .reg_data, .reg_srcaddr,
      .wait_in, .tx_full(full), .tx_prog_full(prog_full), .tx_empty(empty),
      .access_out, .packet_out, .resp_busy, .tx_en, .iowidth, .lsbfirst,
      .framepol, .clkdiv, .clkphase0, .clkphase1, .dstaddr, .clkchange
   );

   mio_fifo u_fifo (
      .clk, .nreset, .push, .push_data, .pop, .rd_data, .full, .prog_full, .empty
   );

   mio_tx u_tx (
      .clk, .nreset, .tx_en, .iowidth, .lsbfirst, .framepol, .clkdiv,
      .empty, .rd_data, .pop, .tx_data, .tx_frame
   );

endmodule

`default_nettype wire

/* mio_tx.sv */
// Serializer for the MIO transmit pins.
// Takes one word from the FIFO when enabled, then shifts it out over
// 1, 2, 4 or 8 low pins per beat. Each beat lasts clkdiv+1 cycles.
// Lane width, bit order and divider are latched when the word loads.

`timescale 1ns/10ps
`default_nettype none

module mio_tx (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          tx_en,
   input  wire  [1:0]                   iowidth,
   input  wire                          lsbfirst,
   input  wire                          framepol,
   input  wire  [7:0]                   clkdiv,
   input  wire                          empty,
   input  wire  [31:0]                  rd_data,
   output logic                         pop,
   output logic [mio_pkg::mio_pins-1:0] tx_data,
   output logic                         tx_frame
);
   import mio_pkg::*;

   logic                busy;            // word on the pins
   logic [31:0]         shreg;           // remaining bits
   logic [5:0]          beat_cnt;        // beats left after this one
   logic [7:0]          div_cnt;         // cycles left in this beat
   logic [7:0]          div_q;
   logic [1:0]          width_q;
   logic                lsb_q;
   logic                beat_end;
   logic [3:0]          step;            // bits per beat
   logic [mio_pins-1:0] mask;
   logic [mio_pins-1:0] lanes;

   assign pop      = ~busy & tx_en & ~empty;     // load head word
   assign beat_end = busy & (div_cnt == 8'd0);
   assign step     = 4'd1 << width_q;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         busy     <= 1'b0;
         beat_cnt <= '0;
         div_cnt  <= '0;
         div_q    <= '0;
         width_q  <= '0;
         lsb_q    <= 1'b0;
      end
      else if (pop)
      begin
         busy     <= 1'b1;
         beat_cnt <= (6'd32 >> iowidth) - 6'd1;
         div_cnt  <= clkdiv;
         div_q    <= clkdiv;
         width_q  <= iowidth;
         lsb_q    <= lsbfirst;
      end
      else if (busy)
      begin
         if (!beat_end)
            div_cnt <= div_cnt - 8'd1;
         else if (beat_cnt == 6'd0)
            busy <= 1'b0;                        // idle cycle between words
         else
         begin
            beat_cnt <= beat_cnt - 6'd1;
            div_cnt  <= div_q;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
         shreg <= rd_data;
      else if (beat_end)
         shreg <= lsb_q ? (shreg >> step) : (shreg << step);
   end

   // msb-first puts the top bits on the low pins, highest bit on top pin
   always_comb
   begin
      mask  = {mio_pins{1'b1}} >> (4'(mio_pins) - step);
      lanes = lsb_q ? shreg[mio_pins-1:0]
                    : shreg[31 -: mio_pins] >> (4'(mio_pins) - step);
      tx_data  = busy ? (lanes & mask) : '0;
      tx_frame = busy ? ~framepol : framepol;
   end

endmodule

`default_nettype wire

/* mio_fifo.sv */
// Synchronous word FIFO between the decoder and the serializer.
// rd_data always shows the head word; pop advances past it.
// Flags are full, prog_full at the configured level, and empty.

`timescale 1ns/10ps
`default_nettype none

module mio_fifo #(
   parameter int DEPTH = mio_pkg::mio_fifo_depth
) (
   input  wire         clk,
   input  wire         nreset,
   input  wire         push,
   input  wire  [31:0] push_data,
   input  wire         pop,
   output logic [31:0] rd_data,
   output logic        full,
   output logic        prog_full,
   output logic        empty
);
   import mio_pkg::*;

   localparam int AW = $clog2(DEPTH);         // pointer width
   localparam int CW = $clog2(DEPTH + 1);     // count width

   logic [31:0]   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10   : count <= count + 1'b1;
            2'b01   : count <= count - 1'b1;
            default : count <= count;         // none or both
         endcase
      end
   end

   assign rd_data   = mem[rd_ptr];            // head word
   assign full      = count == CW'(DEPTH);
   assign prog_full = count >= CW'(mio_prog_full_level);
   assign empty     = count == '0;

   a_no_overflow : assert property (@(posedge clk) disable iff (!nreset)
      push |-> !full);
   a_no_underflow : assert property (@(posedge clk) disable iff (!nreset)
      pop |-> !empty);

endmodule

`default_nettype wire

/* mio_regs.sv */
// Configuration and status registers of the MIO link.
// Writes come from the decoder as one-cycle strobes. A read loads a
// response packet on access_out/packet_out, held while wait_in is high.
// STATUS keeps live fifo flags in [7:0] and sticky copies in [15:8].

`timescale 1ns/10ps
`default_nettype none

`include "mio_regmap.svh"

module mio_regs (
   input  wire                        clk,
   input  wire                        nreset,
   input  wire                        reg_access,
   input  wire                        reg_write,
   input  wire  [3:0]                 reg_addr,
   input  wire  [31:0]                reg_data,
   input  wire  [31:0]                reg_srcaddr,
   input  wire                        wait_in,
   input  wire                        tx_full,
   input  wire                        tx_prog_full,
   input  wire                        tx_empty,
   output logic                       access_out,
   output logic [mio_pkg::mio_pw-1:0] packet_out,
   output logic                       resp_busy,
   output logic                       tx_en,
   output logic [1:0]                 iowidth,
   output logic                       lsbfirst,
   output logic                       framepol,
   output logic [7:0]                 clkdiv,
   output logic [15:0]                clkphase0,
   output logic [15:0]                clkphase1,
   output logic [31:0]                dstaddr,
   output logic                       clkchange
);
   import mio_pkg::*;

   logic [20:0]       config_reg;
   logic [15:0]       status_reg;
   logic [7:0]        clkdiv_reg;
   logic [31:0]       clkphase_reg;
   logic [63:0]       addr_reg;
   logic [7:0]        status_in;       // live flags
   logic              wr;
   logic              rd_req;
   logic [31:0]       rd_value;
   logic [mio_pw-1:0] resp_pkt;

   assign wr     = reg_access & reg_write;
   assign rd_req = reg_access & ~reg_write;

   // ############################
   // config
   // ############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         config_reg <= mio_def_cfg;
      else if (wr && reg_addr == `MIO_CONFIG)
         config_reg <= reg_data[20:0];
   end

   assign tx_en    = ~config_reg[0];       // bit 0 is tx disable
   assign iowidth  = config_reg[5:4];      // 1/2/4/8 lanes
   assign lsbfirst = config_reg[13];
   assign framepol = config_reg[14];       // 0 = frame active high

   // ############################
   // status
   // ############################
   assign status_in = {2'b00, tx_full, tx_prog_full, tx_empty, 3'b000}; // rx unused

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         status_reg <= '0;
      else if (wr && reg_addr == `MIO_STATUS)
         status_reg <= {8'h00, status_in};                 // clear sticky
      else
         status_reg <= {status_reg[15:8] | status_in, status_in};
   end

   // ############################
   // clock and address
   // ############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         clkdiv_reg   <= mio_def_clk;
         clkphase_reg <= {mio_def_fall1, mio_def_rise1, mio_def_fall0, mio_def_rise0};
      end
      else
      begin
         if (wr && reg_addr == `MIO_CLKDIV)
            clkdiv_reg <= reg_data[7:0];
         if (wr && reg_addr == `MIO_CLKPHASE)
            clkphase_reg <= reg_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr && reg_addr == `MIO_ADDR0)
         addr_reg[31:0] <= reg_data;
      if (wr && reg_addr == `MIO_ADDR1)
         addr_reg[63:32] <= reg_data;
   end

   assign clkdiv    = clkdiv_reg;
   assign clkphase0 = clkphase_reg[15:0];  // rise in [7:0], fall in [15:8]
   assign clkphase1 = clkphase_reg[31:16];
   assign dstaddr   = addr_reg[31:0];
   assign clkchange = wr & (reg_addr == `MIO_CLKDIV || reg_addr == `MIO_CLKPHASE);

   // ############################
   // readback
   // ############################
   always_comb
   begin
      case (reg_addr)
         `MIO_CONFIG   : rd_value = {11'd0, config_reg};
         `MIO_STATUS   : rd_value = {16'd0, status_reg};
         `MIO_CLKDIV   : rd_value = {24'd0, clkdiv_reg};
         `MIO_CLKPHASE : rd_value = clkphase_reg;
         `MIO_ADDR0    : rd_value = addr_reg[31:0];
         `MIO_ADDR1    : rd_value = addr_reg[63:32];
         default       : rd_value = '0;
      endcase
   end

   always_comb
   begin
      resp_pkt = '0;                                        // write bit clear
      resp_pkt[mio_dm_lsb +: 2]        = 2'b10;             // 32-bit word
      resp_pkt[mio_cm_lsb +: 5]        = config_reg[20:16];
      resp_pkt[mio_dst_lsb +: mio_aw]  = reg_srcaddr;       // back to sender
      resp_pkt[mio_data_lsb +: mio_aw] = rd_value;
      resp_pkt[mio_src_lsb +: mio_aw]  = {mio_reg_base, 14'd0, reg_addr, 2'b00};
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else if (rd_req)
         access_out <= 1'b1;
      else if (!wait_in)
         access_out <= 1'b0;                                // taken by host
   end

   always_ff @(posedge clk)
   begin
      if (rd_req)
         packet_out <= resp_pkt;
   end

   assign resp_busy = access_out & wait_in;                 // response stalled

   a_resp_hold : assert property (@(posedge clk) disable iff (!nreset)
      access_out && wait_in |=> access_out && $stable(packet_out));

endmodule

`default_nettype wire

/* mio_decode.sv */
// Packet decoder for the MIO transmit path.
// Captures host packets, then routes each one either to the register
// block or into the tx FIFO. Two register stages; the second stage
// holds its entry while the FIFO is full or a read response is stalled.

`timescale 1ns/10ps
`default_nettype none

module mio_decode (
   input  wire                        clk,
   input  wire                        nreset,
   input  wire                        access_in,
   input  wire [mio_pkg::mio_pw-1:0]  packet_in,
   input  wire                        fifo_full,
   input  wire                        resp_busy,
   output logic                       wait_out,
   output logic                       reg_access,
   output logic                       reg_write,
   output logic [3:0]                 reg_addr,
   output logic [31:0]                reg_data,
   output logic [31:0]                reg_srcaddr,
   output logic                       push,
   output logic [31:0]                push_data
);
   import mio_pkg::*;

   logic              s1_valid;         // captured packet present
   logic [mio_pw-1:0] s1_pkt;           // raw packet
   logic              s2_valid;         // routed entry present
   logic              s2_reg;           // hit in register window
   logic              s2_write;
   logic [3:0]        s2_addr;
   logic [31:0]       s2_data;
   logic [31:0]       s2_src;
   logic              s2_hold;          // entry cannot leave this cycle

   assign s2_hold  = s2_valid & (s2_reg ? (~s2_write & resp_busy)
                                        : (s2_write & fifo_full));
   assign wait_out = fifo_full | resp_busy;   // host holds its packet

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else if (!s2_hold)
      begin
         s1_valid <= access_in & ~wait_out;   // accept
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!s2_hold)
      begin
         s1_pkt   <= packet_in;
         s2_reg   <= s1_pkt[mio_dst_lsb+20 +: 12] == mio_reg_base;
         s2_write <= s1_pkt[mio_wr_bit];
         s2_addr  <= s1_pkt[mio_dst_lsb+2 +: 4];     // word offset
         s2_data  <= s1_pkt[mio_data_lsb +: mio_aw];
         s2_src   <= s1_pkt[mio_src_lsb +: mio_aw];  // return address
      end
   end

   // reads outside the window are dropped
   assign reg_access  = s2_valid & s2_reg & ~(~s2_write & resp_busy);
   assign push        = s2_valid & ~s2_reg & s2_write & ~fifo_full;
   assign reg_write   = s2_write;
   assign reg_addr    = s2_addr;
   assign reg_data    = s2_data;
   assign reg_srcaddr = s2_src;
   assign push_data   = s2_data;

   // host keeps a stalled packet until it is taken
   a_host_holds : assert property (@(posedge clk) disable iff (!nreset)
      access_in && wait_out |=> access_in && $stable(packet_in));

endmodule

`default_nettype wire

/* mio_pkg.sv */
// Shared constants for the MIO transmit subsystem.
// Holds emesh packet field positions, the register window, reset
// defaults and FIFO sizing. Import it wherever these are needed.

`default_nettype none

package mio_pkg;

   // ############################
   // packet format
   // ############################
   localparam int mio_pw       = 104;           // emesh packet width
   localparam int mio_aw       = 32;            // address and data width
   localparam int mio_wr_bit   = 0;             // write flag
   localparam int mio_dm_lsb   = 1;             // datamode 2:1
   localparam int mio_cm_lsb   = 3;             // ctrlmode 7:3
   localparam int mio_dst_lsb  = 8;             // dstaddr 39:8
   localparam int mio_data_lsb = 40;            // data 71:40
   localparam int mio_src_lsb  = 72;            // srcaddr 103:72

   // ############################
   // register window and defaults
   // ############################
   localparam logic [11:0] mio_reg_base = 12'h800;   // dstaddr[31:20] match
   localparam int          mio_pins     = 8;         // tx data pins

   localparam logic [20:0] mio_def_cfg = 21'h01070;  // 8 lanes, tx and rx on
   localparam logic [7:0]  mio_def_clk = 8'd7;       // divide by 8

   // phase defaults spread over one divided period
   localparam logic [7:0] mio_def_rise0 = 8'd0;                        // 0 deg
   localparam logic [7:0] mio_def_fall0 = (mio_def_clk + 8'd1) >> 1;   // 180 deg
   localparam logic [7:0] mio_def_rise1 = (mio_def_clk + 8'd1) >> 2;   // 90 deg
   localparam logic [7:0] mio_def_fall1 = mio_def_rise1 + mio_def_fall0; // 270

   // ############################
   // tx fifo
   // ############################
   localparam int mio_fifo_depth      = 16;     // words
   localparam int mio_prog_full_level = 12;     // early warning level

endpackage

`default_nettype wire

/* mio_regmap.svh */
// Word offsets of the MIO configuration registers.
// Compared against dstaddr[5:2] of a packet that hits the register
// window. Included by the register block and the testbench.

`ifndef MIO_REGMAP_SVH
`define MIO_REGMAP_SVH

`define MIO_CONFIG   4'h0   // tx/rx enables, lane width, bit order
`define MIO_STATUS   4'h1   // fifo flags, sticky copies above
`define MIO_CLKDIV   4'h2   // beat length minus one
`define MIO_CLKPHASE 4'h3   // rise/fall phases of both clocks
`define MIO_ADDR0    4'h4   // destination address low
`define MIO_ADDR1    4'h5   // destination address high

`endif
